// ==== flist.f ====
source/temp_pkg.sv
source/i2c_tmp2_reader.sv
source/temp_converter.sv
source/seg7_display.sv
source/temp_display_top.sv
sim/tmp2_i2c_model.sv
sim/temp_display_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module temp_display_tb \
    -f flist.f -o temp_display_sim > build.log 2>&1 \
    && { ./obj_dir/temp_display_sim > sim.log 2>&1 || true; } \
    && grep -qx "RESULT: PASS" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see build.log and sim.log"; exit 1; }

// ==== sim/temp_display_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module temp_display_tb;

    localparam int I2C_DIV        = 4;
    localparam int POLL_CYCLES    = 200;
    localparam int REFRESH_CYCLES = 16;
    localparam int NUM_READS      = 20;
    localparam int CYCLE_LIMIT    = NUM_READS * (POLL_CYCLES + 40 * 4 * I2C_DIV) * 2;

    logic             clk_100MHz;
    logic             rst;
    logic             sw;
    wire              sda;
    wire              scl;
    wire              sda_oe;
    temp_pkg::seg_t   seg;
    temp_pkg::anode_t an;
    logic [7:0]       tx_msb;
    logic [7:0]       tx_lsb;
    wire              start_seen;
    wire              read_done;
    wire              proto_err;
    int               read_count;
    integer           seed;
    int               cycle_cnt;
    int               idle_cycles;              // Cycles since reset or the last read
    int               hold_cnt;
    temp_pkg::anode_t prev_an;

    temp_display_top #(
        .I2C_DIV        (I2C_DIV),
        .POLL_CYCLES    (POLL_CYCLES),
        .REFRESH_CYCLES (REFRESH_CYCLES)
    ) uut (
        .clk_100MHz (clk_100MHz),
        .rst        (rst),
        .sw         (sw),
        .sda_in     (sda),
        .scl        (scl),
        .sda_oe     (sda_oe),
        .seg        (seg),
        .an         (an)
    );

    tmp2_i2c_model u_sensor (
        .clk_100MHz (clk_100MHz),
        .rst        (rst),
        .scl        (scl),
        .sda_oe     (sda_oe),
        .tx_msb     (tx_msb),
        .tx_lsb     (tx_lsb),
        .sda        (sda),
        .start_seen (start_seen),
        .read_done  (read_done),
        .proto_err  (proto_err),
        .read_count (read_count)
    );

    always #5 clk_100MHz = ~clk_100MHz;

    task automatic stop_on_failure();
        $display("RESULT: FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_seg(input temp_pkg::seg_t actual, input temp_pkg::seg_t expected);
        if (actual !== expected) begin
            $display("** Error at %0t: seg expected %b, got %b", $time, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_an(input temp_pkg::anode_t actual, input temp_pkg::anode_t expected);
        if (actual !== expected) begin
            $display("** Error at %0t: an expected %b, got %b", $time, expected, actual);
            stop_on_failure();
        end
    endtask

    // Sensor reading from -25 to 124 degrees, raw two's complement
    function automatic logic [7:0] random_reading();
        int r;
        r = int'($unsigned($random(seed)) % 150);
        return 8'(r - 25);
    endfunction

    function automatic int expected_celsius(input logic [7:0] raw);
        if ($signed(raw) < 0)
            return 0;                           // Below zero clamps
        return int'(raw);
    endfunction

    function automatic temp_pkg::seg_t digit_pattern(input int d);
        case (d)
            0: return temp_pkg::SEG_ZERO;
            1: return temp_pkg::SEG_ONE;
            2: return temp_pkg::SEG_TWO;
            3: return temp_pkg::SEG_THREE;
            4: return temp_pkg::SEG_FOUR;
            5: return temp_pkg::SEG_FIVE;
            6: return temp_pkg::SEG_SIX;
            7: return temp_pkg::SEG_SEVEN;
            8: return temp_pkg::SEG_EIGHT;
            default: return temp_pkg::SEG_NINE;
        endcase
    endfunction

    task automatic wait_for_read();
        do @(negedge clk_100MHz); while (!read_done);
    endtask

    // One full rotation, every position compared on every cycle
    task automatic check_display(input int value, input logic fahrenheit);
        temp_pkg::seg_t expected;
        repeat (4 * REFRESH_CYCLES) begin
            @(negedge clk_100MHz);
            case (an)
                4'b1110: expected = fahrenheit ? temp_pkg::SEG_F : temp_pkg::SEG_C;
                4'b1101: expected = temp_pkg::SEG_DEG;
                4'b1011: expected = digit_pattern(value % 10);
                default: expected = digit_pattern((value / 10) % 10);
            endcase
            check_seg(seg, expected);
        end
    endtask

    always @(posedge clk_100MHz) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles with %0d reads done", cycle_cnt, read_count);
            stop_on_failure();
        end
    end

    // Bus protocol and poll interval
    always @(negedge clk_100MHz) begin
        if (proto_err) begin
            $display("The sensor model saw a bus protocol violation");
            stop_on_failure();
        end
        if (rst) begin
            idle_cycles = 0;
        end else if (start_seen) begin
            if (idle_cycles < POLL_CYCLES) begin
                $display("A read started %0d cycles after the last one", idle_cycles);
                stop_on_failure();
            end
        end else if (read_done) begin
            idle_cycles = 0;
        end else begin
            idle_cycles = idle_cycles + 1;
        end
    end

    // Digit rotation order and dwell time
    always @(negedge clk_100MHz) begin
        if (rst) begin
            hold_cnt = -1;                      // Release edge still sees reset
            prev_an  = 4'b1110;
        end else begin
            hold_cnt = hold_cnt + 1;
            if (an != prev_an) begin
                check_an(an, {prev_an[2:0], prev_an[3]});
                if (hold_cnt != REFRESH_CYCLES) begin
                    $display("Digit %b stayed on for %0d cycles", prev_an, hold_cnt);
                    stop_on_failure();
                end
                prev_an  = an;
                hold_cnt = 0;
            end else if (hold_cnt > REFRESH_CYCLES) begin
                $display("Digit %b stayed on past %0d cycles", an, REFRESH_CYCLES);
                stop_on_failure();
            end
        end
    end

    initial begin
        int         c_exp;
        int         f_exp;
        logic [7:0] cur_msb;
        logic       cur_sw;
        seed       = 32'h7490_d6e3;
        cycle_cnt  = 0;
        clk_100MHz = 1'b0;
        rst        = 1'b1;
        sw         = 1'b0;
        tx_msb     = 8'd0;
        tx_lsb     = 8'd0;
        cur_msb    = random_reading();
        cur_sw     = 1'($random(seed));
        @(posedge clk_100MHz);
        @(posedge clk_100MHz);
        rst    <= 1'b0;
        sw     <= cur_sw;
        tx_msb <= cur_msb;
        tx_lsb <= 8'($random(seed));
        @(negedge clk_100MHz);
        check_an(an, 4'b1110);
        check_seg(seg, cur_sw ? temp_pkg::SEG_F : temp_pkg::SEG_C);

        for (int i = 0; i < NUM_READS; i++) begin
            wait_for_read();
            c_exp   = expected_celsius(cur_msb);
            f_exp   = c_exp * 9 / 5 + 32;
            cur_msb = random_reading();
            cur_sw  = 1'($random(seed));
            @(posedge clk_100MHz);
            tx_msb <= cur_msb;                  // Served on the next poll
            tx_lsb <= 8'($random(seed));
            sw     <= cur_sw;
            repeat (4 * REFRESH_CYCLES) @(negedge clk_100MHz);
            check_display(cur_sw ? f_exp : c_exp, cur_sw);
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/tmp2_i2c_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module tmp2_i2c_model (
    input  wire        clk_100MHz,
    input  wire        rst,
    input  wire        scl,
    input  wire        sda_oe,                  // Master pulls SDA low
    input  wire  [7:0] tx_msb,
    input  wire  [7:0] tx_lsb,
    output logic       sda,                     // Resolved line level
    output logic       start_seen,              // One pulse per start condition
    output logic       read_done,               // One pulse per completed read
    output logic       proto_err,
    output int         read_count
);

    typedef enum logic [2:0] {
        M_IDLE, M_ADDR, M_ADDR_ACK, M_MSB, M_MSB_ACK, M_LSB, M_LSB_ACK, M_STOP
    } bus_state_t;

    bus_state_t state;
    logic       pull;                           // Sensor pulls SDA low
    logic       scl_q;
    logic       sda_q;
    logic [3:0] bit_cnt;
    logic [7:0] addr_sh;

    assign sda = ~sda_oe & ~pull;               // Open drain with pull-up

    always @(posedge clk_100MHz) begin
        start_seen <= 1'b0;
        read_done  <= 1'b0;
        if (rst) begin
            state      <= M_IDLE;
            pull       <= 1'b0;
            scl_q      <= 1'b1;
            sda_q      <= 1'b1;
            bit_cnt    <= 4'd0;
            addr_sh    <= 8'd0;
            proto_err  <= 1'b0;
            read_count <= 0;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl && scl_q && sda != sda_q) begin
                if (!sda) begin                 // Start condition
                    if (state != M_IDLE) begin
                        $display("Bus error at %0t: start condition inside a read", $time);
                        proto_err <= 1'b1;
                    end
                    start_seen <= 1'b1;
                    state      <= M_ADDR;
                    bit_cnt    <= 4'd0;
                end else if (state == M_STOP) begin
                    read_done  <= 1'b1;
                    read_count <= read_count + 1;
                    state      <= M_IDLE;
                end else begin
                    $display("Bus error at %0t: stop condition before the read ended", $time);
                    proto_err <= 1'b1;
                end
            end else if (scl && !scl_q) begin   // Rising SCL, receiver samples
                case (state)
                    M_IDLE: begin
                        $display("Bus error at %0t: clock pulse outside a read", $time);
                        proto_err <= 1'b1;
                    end
                    M_ADDR: begin
                        addr_sh <= {addr_sh[6:0], sda};
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                    M_MSB, M_LSB: bit_cnt <= bit_cnt + 1'b1;
                    M_MSB_ACK: if (sda) begin
                        $display("Bus error at %0t: first data byte was not acknowledged", $time);
                        proto_err <= 1'b1;
                    end
                    M_LSB_ACK: if (!sda) begin
                        $display("Bus error at %0t: last data byte was acknowledged", $time);
                        proto_err <= 1'b1;
                    end
                    default: ;
                endcase
            end else if (!scl && scl_q) begin   // Falling SCL, sensor sets up its next bit
                case (state)
                    M_ADDR: if (bit_cnt == 4'd8) begin
                        if (addr_sh != {temp_pkg::TMP2_ADDR, 1'b1}) begin
                            $display("Bus error at %0t: address byte %h is not a sensor read",
                                     $time, addr_sh);
                            proto_err <= 1'b1;
                        end else begin
                            pull <= 1'b1;       // ACK
                        end
                        state <= M_ADDR_ACK;
                    end
                    M_ADDR_ACK, M_MSB_ACK: begin
                        pull    <= (state == M_ADDR_ACK) ? ~tx_msb[7] : ~tx_lsb[7];
                        bit_cnt <= 4'd0;
                        state   <= (state == M_ADDR_ACK) ? M_MSB : M_LSB;
                    end
                    M_MSB, M_LSB: begin
                        if (bit_cnt == 4'd8) begin
                            pull  <= 1'b0;      // Release for the master's answer
                            state <= (state == M_MSB) ? M_MSB_ACK : M_LSB_ACK;
                        end else if (state == M_MSB) begin
                            pull <= ~tx_msb[3'(4'd7 - bit_cnt)];
                        end else begin
                            pull <= ~tx_lsb[3'(4'd7 - bit_cnt)];
                        end
                    end
                    M_LSB_ACK: state <= M_STOP;
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/temp_display_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module temp_display_top #(
    parameter int I2C_DIV        = 250,         // 100 kHz SCL from 100 MHz
    parameter int POLL_CYCLES    = 25_000_000,  // Four reads per second
    parameter int REFRESH_CYCLES = 100_000      // 1 ms per digit
) (
    input  wire               clk_100MHz,
    input  wire               rst,
    input  wire               sw,               // Celsius or Fahrenheit
    input  wire               sda_in,
    output logic              scl,
    output logic              sda_oe,
    output temp_pkg::seg_t    seg,
    output temp_pkg::anode_t  an
);

    logic [7:0]      c_data;
    logic            c_valid;
    temp_pkg::temp_t temp;
    logic            temp_valid;

    // Sensor polling over I2C
    i2c_tmp2_reader #(
        .I2C_DIV     (I2C_DIV),
        .POLL_CYCLES (POLL_CYCLES)
    ) u_reader (
        .clk_100MHz (clk_100MHz),
        .rst        (rst),
        .sda_in     (sda_in),
        .scl        (scl),
        .sda_oe     (sda_oe),
        .c_data     (c_data),
        .c_valid    (c_valid)
    );

    temp_converter u_converter (
        .clk_100MHz (clk_100MHz),
        .rst        (rst),
        .c_data     (c_data),
        .c_valid    (c_valid),
        .temp       (temp),
        .temp_valid (temp_valid)
    );

    // Four-digit multiplexed output
    seg7_display #(
        .REFRESH_CYCLES (REFRESH_CYCLES)
    ) u_display (
        .clk_100MHz (clk_100MHz),
        .rst        (rst),
        .sw         (sw),
        .temp       (temp),
        .temp_valid (temp_valid),
        .seg        (seg),
        .an         (an)
    );

endmodule

`default_nettype wire

// ==== source/seg7_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module seg7_display #(
    parameter int REFRESH_CYCLES = 100_000      // Clocks per digit
) (
    input  wire                   clk_100MHz,
    input  wire                   rst,
    input  wire                   sw,           // High selects Fahrenheit
    input  wire temp_pkg::temp_t  temp,
    input  wire                   temp_valid,
    output temp_pkg::seg_t        seg,
    output temp_pkg::anode_t      an
);

    localparam int REF_W = $clog2(REFRESH_CYCLES + 1);

    temp_pkg::temp_t  temp_q;                   // Latest converted pair
    logic [REF_W-1:0] refresh_cnt;
    logic [1:0]       digit_sel;
    logic [7:0]       value;
    logic [3:0]       tens;
    logic [3:0]       ones;

    // Pattern for a single decimal digit
    function automatic temp_pkg::seg_t digit_seg(input logic [3:0] d);
        temp_pkg::seg_t s;
        case (d)
            4'd0:    s = temp_pkg::SEG_ZERO;
            4'd1:    s = temp_pkg::SEG_ONE;
            4'd2:    s = temp_pkg::SEG_TWO;
            4'd3:    s = temp_pkg::SEG_THREE;
            4'd4:    s = temp_pkg::SEG_FOUR;
            4'd5:    s = temp_pkg::SEG_FIVE;
            4'd6:    s = temp_pkg::SEG_SIX;
            4'd7:    s = temp_pkg::SEG_SEVEN;
            4'd8:    s = temp_pkg::SEG_EIGHT;
            4'd9:    s = temp_pkg::SEG_NINE;
            default: s = '1;                    // Blank
        endcase
        return s;
    endfunction

    always_ff @(posedge clk_100MHz) begin
        if (rst)
            temp_q <= '0;
        else if (temp_valid)
            temp_q <= temp;
    end

    // Each digit stays lit for REFRESH_CYCLES clocks
    always_ff @(posedge clk_100MHz) begin
        if (rst) begin
            refresh_cnt <= '0;
            digit_sel   <= 2'd0;
        end else if (refresh_cnt == REF_W'(REFRESH_CYCLES - 1)) begin
            refresh_cnt <= '0;
            digit_sel   <= digit_sel + 1'b1;
        end else begin
            refresh_cnt <= refresh_cnt + 1'b1;
        end
    end

    always_comb begin
        case (digit_sel)
            2'd0:    an = 4'b1110;
            2'd1:    an = 4'b1101;
            2'd2:    an = 4'b1011;
            2'd3:    an = 4'b0111;
            default: an = temp_pkg::AN_OFF;
        endcase
    end

    // Split the selected scale into two decimal digits
    assign value = sw ? temp_q.f_data : temp_q.c_data;
    assign tens  = 4'((value / 8'd10) % 8'd10);
    assign ones  = 4'(value % 8'd10);

    always_comb begin
        case (digit_sel)
            2'd0:    seg = sw ? temp_pkg::SEG_F : temp_pkg::SEG_C;    // Unit letter
            2'd1:    seg = temp_pkg::SEG_DEG;
            2'd2:    seg = digit_seg(ones);
            2'd3:    seg = digit_seg(tens);
            default: seg = '1;
        endcase
    end

    // Exactly one digit is lit at any time
    assert property (@(posedge clk_100MHz) disable iff (rst)
        $onehot(~an));

endmodule

`default_nettype wire

// ==== source/temp_converter.sv ====
`timescale 1ns/1ps
`default_nettype none

module temp_converter (
    input  wire                  clk_100MHz,
    input  wire                  rst,
    input  wire  [7:0]           c_data,
    input  wire                  c_valid,
    output temp_pkg::temp_t      temp,
    output logic                 temp_valid
);

    logic [7:0] f_calc;

    // F = C * 9 / 5 + 32, truncated, kept to 8 bits
    assign f_calc = 8'((12'(c_data) * 12'd9) / 12'd5 + 12'd32);

    always_ff @(posedge clk_100MHz) begin
        if (rst)
            temp_valid <= 1'b0;
        else
            temp_valid <= c_valid;
    end

    always_ff @(posedge clk_100MHz) begin
        if (c_valid) begin
            temp.c_data <= c_data;
            temp.f_data <= f_calc;
        end
    end

    // One reading in flight at a time
    assert property (@(posedge clk_100MHz) disable iff (rst)
        c_valid |=> !c_valid);

endmodule

`default_nettype wire

// ==== source/i2c_tmp2_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_tmp2_reader #(
    parameter int I2C_DIV     = 250,            // Clocks per quarter SCL period
    parameter int POLL_CYCLES = 25_000_000      // Idle clocks between reads
) (
    input  wire        clk_100MHz,
    input  wire        rst,
    input  wire        sda_in,                  // Resolved SDA level
    output logic       scl,
    output logic       sda_oe,                  // High pulls SDA low
    output logic [7:0] c_data,                  // Clamped Celsius reading
    output logic       c_valid
);

    localparam int DIV_W  = $clog2(I2C_DIV + 1);
    localparam int POLL_W = $clog2(POLL_CYCLES + 1);
    localparam logic [7:0] ADDR_RD = {temp_pkg::TMP2_ADDR, 1'b1};  // Address plus read bit

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_START,
        ST_ADDR,
        ST_ADDR_ACK,
        ST_MSB,
        ST_MSB_ACK,
        ST_LSB,
        ST_LSB_NACK,
        ST_STOP,
        ST_DONE
    } state_t;

    state_t            state;
    logic [DIV_W-1:0]  div_cnt;                 // Clocks within a quarter bit
    logic [1:0]        phase;                   // Quarter within a bit
    logic [2:0]        bit_cnt;                 // Bit index, MSB first
    logic [POLL_W-1:0] poll_cnt;
    logic              nack;                    // Address not acknowledged
    logic [15:0]       rx_q;                    // Received MSB and LSB
    logic              tick;
    logic              bit_scl;
    logic              scl_d;
    logic              oe_d;

    assign tick    = (div_cnt == DIV_W'(I2C_DIV - 1));
    assign bit_scl = (phase == 2'd1) || (phase == 2'd2);   // High in the middle two quarters

    // Bus levels for the current state and quarter
    always_comb begin
        scl_d = 1'b1;
        oe_d  = 1'b0;
        case (state)
            ST_START: begin
                scl_d = (phase != 2'd3);
                oe_d  = (phase != 2'd0);        // SDA falls while SCL is high
            end
            ST_ADDR: begin
                scl_d = bit_scl;
                oe_d  = ~ADDR_RD[bit_cnt];
            end
            ST_ADDR_ACK, ST_MSB, ST_LSB, ST_LSB_NACK: begin
                scl_d = bit_scl;                // Slave drives, or NACK on the last byte
            end
            ST_MSB_ACK: begin
                scl_d = bit_scl;
                oe_d  = 1'b1;                   // ACK the first byte
            end
            ST_STOP: begin
                scl_d = (phase != 2'd0);
                oe_d  = (phase <= 2'd1);        // SDA rises while SCL is high
            end
            default: begin
                scl_d = 1'b1;
                oe_d  = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk_100MHz) begin
        if (rst) begin
            state    <= ST_IDLE;
            div_cnt  <= '0;
            phase    <= 2'd0;
            bit_cnt  <= 3'd7;
            poll_cnt <= '0;
            nack     <= 1'b0;
            c_valid  <= 1'b0;
            scl      <= 1'b1;
            sda_oe   <= 1'b0;
        end else begin
            c_valid <= 1'b0;
            scl     <= scl_d;
            sda_oe  <= oe_d;
            case (state)
                ST_IDLE: begin
                    if (poll_cnt == POLL_W'(POLL_CYCLES - 1)) begin
                        poll_cnt <= '0;
                        div_cnt  <= '0;
                        phase    <= 2'd0;
                        nack     <= 1'b0;
                        state    <= ST_START;
                    end else begin
                        poll_cnt <= poll_cnt + 1'b1;
                    end
                end
                ST_DONE: begin
                    c_valid <= ~nack;           // No strobe after an address NACK
                    state   <= ST_IDLE;
                end
                default: begin
                    if (!tick) begin
                        div_cnt <= div_cnt + 1'b1;
                    end else begin
                        div_cnt <= '0;
                        phase   <= phase + 1'b1;
                        if (phase == 2'd2 && state == ST_ADDR_ACK)
                            nack <= sda_in;     // Sample ACK mid-high
                        if (phase == 2'd3) begin
                            case (state)
                                ST_START: begin
                                    bit_cnt <= 3'd7;
                                    state   <= ST_ADDR;
                                end
                                ST_ADDR: begin
                                    if (bit_cnt == 3'd0)
                                        state <= ST_ADDR_ACK;
                                    bit_cnt <= bit_cnt - 1'b1;
                                end
                                ST_ADDR_ACK: begin
                                    bit_cnt <= 3'd7;
                                    state   <= nack ? ST_STOP : ST_MSB;
                                end
                                ST_MSB: begin
                                    if (bit_cnt == 3'd0)
                                        state <= ST_MSB_ACK;
                                    bit_cnt <= bit_cnt - 1'b1;
                                end
                                ST_MSB_ACK: begin
                                    bit_cnt <= 3'd7;
                                    state   <= ST_LSB;
                                end
                                ST_LSB: begin
                                    if (bit_cnt == 3'd0)
                                        state <= ST_LSB_NACK;
                                    bit_cnt <= bit_cnt - 1'b1;
                                end
                                ST_LSB_NACK: state <= ST_STOP;
                                ST_STOP:     state <= ST_DONE;
                                default:     state <= ST_IDLE;
                            endcase
                        end
                    end
                end
            endcase
        end
    end

    // Received data and the clamped result
    always_ff @(posedge clk_100MHz) begin
        if (tick && phase == 2'd2 && (state == ST_MSB || state == ST_LSB))
            rx_q <= {rx_q[14:0], sda_in};
        if (state == ST_DONE)
            c_data <= rx_q[15] ? 8'd0 : rx_q[15:8];    // Negative readings show as zero
    end

    // SDA may only fall under a high SCL when opening a transfer
    assert property (@(posedge clk_100MHz) disable iff (rst)
        (sda_oe && !$past(sda_oe) && scl) |-> state == ST_START);

    assert property (@(posedge clk_100MHz) disable iff (rst)
        c_valid |=> !c_valid);

endmodule

`default_nettype wire

// ==== source/temp_pkg.sv ====
`default_nettype none

package temp_pkg;

    // Celsius and Fahrenheit travel together from the converter to the display
    typedef struct packed {
        logic [7:0] c_data;                     // Celsius, 0 to 127
        logic [7:0] f_data;                     // Fahrenheit
    } temp_t;

    typedef logic [0:6] seg_t;                  // Segments a to g, active low
    typedef logic [3:0] anode_t;                // Digit enables, active low

    // Digit patterns
    localparam seg_t SEG_ZERO  = 7'b000_0001;
    localparam seg_t SEG_ONE   = 7'b100_1111;
    localparam seg_t SEG_TWO   = 7'b001_0010;
    localparam seg_t SEG_THREE = 7'b000_0110;
    localparam seg_t SEG_FOUR  = 7'b100_1100;
    localparam seg_t SEG_FIVE  = 7'b010_0100;
    localparam seg_t SEG_SIX   = 7'b010_0000;
    localparam seg_t SEG_SEVEN = 7'b000_1111;
    localparam seg_t SEG_EIGHT = 7'b000_0000;
    localparam seg_t SEG_NINE  = 7'b000_0100;

    // Symbols
    localparam seg_t SEG_DEG   = 7'b001_1100;   // Degree sign
    localparam seg_t SEG_C     = 7'b011_0001;   // Celsius unit
    localparam seg_t SEG_F     = 7'b011_1000;   // Fahrenheit unit

    // All four anodes off
    localparam anode_t AN_OFF  = 4'b1111;

    // 7-bit bus address of the sensor
    localparam logic [6:0] TMP2_ADDR = 7'h4B;

endpackage

`default_nettype wire
